/* spi_slave.f */
spi_slave_pkg.sv
spi_line_sync.sv
spi_slave_driver.sv
spi_rx_fifo.sv
spi_apb_regs.sv
spi_slave_top.sv
spi_slave_properties.sv
tb_spi_slave_top.sv

/* Bender.yml */
package:
  name: spi_slave

sources:
  - spi_slave_pkg.sv
  - spi_line_sync.sv
  - spi_slave_driver.sv
  - spi_rx_fifo.sv
  - spi_apb_regs.sv
  - spi_slave_top.sv
  - target: test
    files:
      - spi_slave_properties.sv
      - tb_spi_slave_top.sv

/* tb_spi_slave_top.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the spi slave subsystem
// spi master model, apb driver and a
// table of receive and transmit vectors
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tb_spi_slave_top import spi_slave_pkg::*; ();

	localparam int half_cycles = 8;
	localparam int num_vectors = 8;
	localparam int fifo_depth = 4;
	localparam int poll_limit = 20;
	// one framed word plus select setup and gap
	localparam int cycles_per_word = (2 * WORD_BITS + 3) * half_cycles;
	localparam int watchdog_cycles = num_vectors * cycles_per_word * 4;

	typedef struct packed {
		logic load;
		spi_word_t tx;
		spi_word_t mosi;
		status_reg_t exp_status;
	} vector_t;

	logic sys_clk;
	logic rst;
	spi_pins_t pins;
	logic miso;
	apb_req_t apb_req;
	apb_rsp_t apb_rsp;

	vector_t vectors [num_vectors];
	spi_word_t fill_words [4];
	integer seed;
	int errors;
	int tests;
	int mark;
	apb_rsp_t resp;
	spi_word_t data;
	spi_word_t miso_word;
	status_reg_t st;

	spi_slave_top #(
		.ss_active_low(1'b1),
		.lsb_first(1'b0),
		.fifo_depth(fifo_depth)
	) i_dut (
		.sys_clk(sys_clk),
		.rst(rst),
		.pins(pins),
		.miso(miso),
		.apb_req(apb_req),
		.apb_rsp(apb_rsp)
	);

	initial begin
		sys_clk = 1'b0;
		forever #50 sys_clk = ~sys_clk;
	end

	// hard stop sized from the vector count
	initial begin
		repeat (watchdog_cycles) @(posedge sys_clk);
		$display("timeout: run did not finish within %0d cycles", watchdog_cycles);
		$display("SIMULATION FAILED");
		$finish;
	end

	// all drives land 10 ns after a rising edge
	task automatic step(input int n);
		repeat (n) @(posedge sys_clk);
		#10;
	endtask

	// setup cycle, access cycle, sample mid access
	task automatic apb_read(input logic [3:0] addr, output spi_word_t rdata,
		output apb_rsp_t rsp);
		step(1);
		apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: '0};
		step(1);
		apb_req.penable = 1'b1;
		@(negedge sys_clk);
		rsp = apb_rsp;
		rdata = apb_rsp.prdata;
		step(1);
		apb_req = '0;
	endtask

	task automatic apb_write(input logic [3:0] addr, input spi_word_t wdata,
		output apb_rsp_t rsp);
		step(1);
		apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: wdata};
		step(1);
		apb_req.penable = 1'b1;
		@(negedge sys_clk);
		rsp = apb_rsp;
		step(1);
		apb_req = '0;
	endtask

	task automatic read_status(output status_reg_t s);
		spi_word_t raw;
		apb_rsp_t rsp;
		apb_read(addr_status, raw, rsp);
		s = status_reg_t'(raw);
	endtask

	// mode 0 master, msb first, mosi set a half period before each rise
	task automatic spi_frame(input spi_word_t mosi_word, input int nbits,
		output spi_word_t sampled);
		sampled = '0;
		step(1);
		pins.ss = 1'b0;
		// room for the slave to load its tx word
		step(half_cycles);
		for (int i = 0; i < nbits; i++) begin
			pins.mosi = mosi_word[WORD_BITS-1-i];
			step(half_cycles);
			pins.sclk = 1'b1;
			sampled[WORD_BITS-1-i] = miso;
			step(half_cycles);
			pins.sclk = 1'b0;
		end
		step(half_cycles);
		pins.ss = 1'b1;
		pins.mosi = 1'b0;
		step(half_cycles);
	endtask

	function automatic status_reg_t status_of(input int cnt, input logic empty,
		input logic txp, input logic ovf, input logic bsy);
		status_reg_t s;
		s.rx_count = fifo_cnt_t'(cnt);
		s.rx_empty = empty;
		s.tx_pending = txp;
		s.overflow = ovf;
		s.busy = bsy;
		return s;
	endfunction

	task automatic check_word(input string what, input spi_word_t got, input spi_word_t exp);
		if (got !== exp) begin
			errors++;
			$display("FAIL %0t: %s got %02h expected %02h", $time, what, got, exp);
		end
	endtask

	task automatic check_status(input string what, input status_reg_t got,
		input status_reg_t exp);
		if (got !== exp) begin
			errors++;
			$display("FAIL %0t: %s status got %02h expected %02h", $time, what, got, exp);
		end
	endtask

	// pready is always high, pslverr as expected
	task automatic check_resp(input string what, input apb_rsp_t got, input logic exp_err);
		if (got.pready !== 1'b1) begin
			errors++;
			$display("FAIL %0t: %s pready got %b expected 1", $time, what, got.pready);
		end
		if (got.pslverr !== exp_err) begin
			errors++;
			$display("FAIL %0t: %s pslverr got %b expected %b", $time, what,
				got.pslverr, exp_err);
		end
	endtask

	// poll STATUS, receive latency is not a fixed cycle count
	task automatic wait_rx_count(input int n);
		status_reg_t s;
		int tries;
		tries = 0;
		read_status(s);
		while (s.rx_count != fifo_cnt_t'(n) && tries < poll_limit) begin
			tries++;
			read_status(s);
		end
		if (s.rx_count != fifo_cnt_t'(n)) begin
			errors++;
			$display("rx_count never reached %0d after %0d status reads", n, tries);
		end
	endtask

	task automatic end_test(input string name, input int err_before);
		tests++;
		if (errors == err_before) begin
			$display("test %0d %s: ok", tests, name);
		end else begin
			$display("test %0d %s: %0d mismatches", tests, name, errors - err_before);
		end
	endtask

	initial begin
		seed = 32'h5ae59dd6;
		errors = 0;
		tests = 0;
		rst = 1'b1;
		// ss idle high, active low select
		pins = '{ss: 1'b1, sclk: 1'b0, mosi: 1'b0};
		apb_req = '0;
		// fixed corner words first, then random ones
		vectors[0] = '{1'b1, 8'hA5, 8'h3C, status_of(1, 0, 0, 0, 0)};
		vectors[1] = '{1'b0, 8'h00, 8'hFF, status_of(1, 0, 0, 0, 0)};
		vectors[2] = '{1'b1, 8'h81, 8'h00, status_of(1, 0, 0, 0, 0)};
		vectors[3] = '{1'b1, 8'h5A, 8'h96, status_of(1, 0, 0, 0, 0)};
		for (int i = 4; i < num_vectors; i++) begin
			vectors[i].load = 1'($random(seed));
			vectors[i].tx = spi_word_t'($random(seed));
			vectors[i].mosi = spi_word_t'($random(seed));
			vectors[i].exp_status = status_of(1, 0, 0, 0, 0);
		end
		fill_words = '{8'h11, 8'hE2, 8'h37, 8'hC8};
		repeat (5) @(posedge sys_clk);
		#10;
		rst = 1'b0;
		step(4);

		// receive and transmit, one word per vector
		for (int i = 0; i < num_vectors; i++) begin
			mark = errors;
			if (vectors[i].load) begin
				apb_write(addr_txdata, vectors[i].tx, resp);
				check_resp("txdata write", resp, 1'b0);
			end
			spi_frame(vectors[i].mosi, WORD_BITS, miso_word);
			wait_rx_count(1);
			read_status(st);
			check_status("after frame", st, vectors[i].exp_status);
			apb_read(addr_rxdata, data, resp);
			check_resp("rxdata read", resp, 1'b0);
			check_word("rxdata", data, vectors[i].mosi);
			read_status(st);
			check_status("after pop", st, status_of(0, 1, 0, 0, 0));
			check_word("miso word", miso_word,
				vectors[i].load ? vectors[i].tx : spi_word_t'(0));
			end_test($sformatf("vector %0d", i), mark);
		end

		// fill the fifo without reading
		mark = errors;
		for (int k = 0; k < 4; k++) begin
			spi_frame(fill_words[k], WORD_BITS, miso_word);
			wait_rx_count(k + 1);
		end
		read_status(st);
		check_status("fifo full", st, status_of(4, 0, 0, 0, 0));
		end_test("fifo fill", mark);

		// fifth word dropped, first four kept in order
		mark = errors;
		spi_frame(8'h99, WORD_BITS, miso_word);
		read_status(st);
		check_status("overflow set", st, status_of(4, 0, 0, 1, 0));
		for (int k = 0; k < 4; k++) begin
			apb_read(addr_rxdata, data, resp);
			check_word("fifo order", data, fill_words[k]);
		end
		read_status(st);
		check_status("drained", st, status_of(0, 1, 0, 1, 0));
		apb_write(addr_status, 8'h01, resp);
		read_status(st);
		check_status("overflow cleared", st, status_of(0, 1, 0, 0, 0));
		end_test("overflow", mark);

		// ss released after 3 bits
		mark = errors;
		spi_frame(8'hA0, 3, miso_word);
		read_status(st);
		check_status("after abort", st, status_of(0, 1, 0, 0, 0));
		spi_frame(8'h5C, WORD_BITS, miso_word);
		wait_rx_count(1);
		apb_read(addr_rxdata, data, resp);
		check_word("word after abort", data, 8'h5C);
		end_test("abort", mark);

		// unmapped address and empty pop
		mark = errors;
		apb_read(4'hC, data, resp);
		check_resp("read 0xC", resp, 1'b1);
		apb_write(4'hC, 8'hFF, resp);
		check_resp("write 0xC", resp, 1'b1);
		read_status(st);
		check_status("after bad access", st, status_of(0, 1, 0, 0, 0));
		apb_read(addr_rxdata, data, resp);
		check_resp("empty rxdata", resp, 1'b0);
		check_word("empty rxdata", data, 8'h00);
		read_status(st);
		check_status("after empty pop", st, status_of(0, 1, 0, 0, 0));
		end_test("bus errors", mark);

		$display("%0d tests, %0d errors", tests, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* spi_slave_properties.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// spi slave protocol assertions
// bound into the subsystem top level
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module spi_slave_properties import spi_slave_pkg::*; #(
	parameter int fifo_depth = 8
) (
	input wire logic sys_clk,
	input wire logic rst,
	input wire logic miso_ready,
	input wire logic miso_start,
	input wire logic rx_valid,
	input wire logic pop,
	input apb_req_t req,
	input apb_rsp_t rsp,
	input fifo_status_t fifo
);

	// driver takes the word and leaves its wait on the next edge
	a_start_ready: assert property (@(posedge sys_clk) disable iff (rst)
		miso_start |=> !miso_ready) else $error("miso_ready held after miso_start");

	// a bus error has no side effect on the fifo
	a_err_access: assert property (@(posedge sys_clk) disable iff (rst)
		rsp.pslverr |-> !pop) else $error("pslverr access popped the fifo");

	a_fifo_bound: assert property (@(posedge sys_clk) disable iff (rst)
		fifo.count <= fifo_depth) else $error("fifo count above depth");

	// one push per received word
	a_rx_pulse: assert property (@(posedge sys_clk) disable iff (rst)
		rx_valid |=> !rx_valid) else $error("rx_valid longer than one cycle");

endmodule

bind spi_slave_top spi_slave_properties #(
	.fifo_depth(fifo_depth)
) i_props (
	.sys_clk(sys_clk),
	.rst(rst),
	.miso_ready(miso_ready),
	.miso_start(miso_start),
	.rx_valid(rx_valid),
	.pop(pop),
	.req(apb_req),
	.rsp(apb_rsp),
	.fifo(fifo_status)
);

`default_nettype wire

/* spi_slave_top.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// spi slave with apb front end
// synchronizer, driver, rx fifo and
// register block
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module spi_slave_top import spi_slave_pkg::*; #(
	parameter bit ss_active_low = 1'b1,
	parameter bit lsb_first = 1'b0,
	parameter int fifo_depth = 8
) (
	input wire logic sys_clk,
	input wire logic rst,
	input spi_pins_t pins,
	output logic miso,
	input apb_req_t apb_req,
	output apb_rsp_t apb_rsp
);

	spi_sync_t sync;
	logic miso_ready;
	logic miso_start;
	logic rx_valid;
	logic busy;
	logic pop;
	spi_word_t rx_word;
	spi_word_t tx_word;
	spi_word_t rd_word;
	fifo_status_t fifo_status;

	spi_line_sync i_sync (
		.sys_clk(sys_clk),
		.rst(rst),
		.pins(pins),
		.sync(sync)
	);

	spi_slave_driver #(
		.ss_active_low(ss_active_low),
		.lsb_first(lsb_first)
	) i_driver (
		.sys_clk(sys_clk),
		.rst(rst),
		.sync(sync),
		.miso_start(miso_start),
		.tx_word(tx_word),
		.miso_ready(miso_ready),
		.rx_valid(rx_valid),
		.rx_word(rx_word),
		.busy(busy),
		.miso(miso)
	);

	// no back-pressure, a full fifo drops the word
	spi_rx_fifo #(
		.fifo_depth(fifo_depth)
	) i_fifo (
		.sys_clk(sys_clk),
		.rst(rst),
		.push(rx_valid),
		.wr_word(rx_word),
		.pop(pop),
		.rd_word(rd_word),
		.status(fifo_status)
	);

	spi_apb_regs i_regs (
		.sys_clk(sys_clk),
		.rst(rst),
		.req(apb_req),
		.rsp(apb_rsp),
		.rx_valid(rx_valid),
		.fifo(fifo_status),
		.rd_word(rd_word),
		.pop(pop),
		.miso_ready(miso_ready),
		.busy(busy),
		.miso_start(miso_start),
		.tx_word(tx_word)
	);

endmodule

`default_nettype wire

/* spi_apb_regs.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// apb register block
// status, rx data pop and tx word
// staging, with sticky overflow
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module spi_apb_regs import spi_slave_pkg::*; (
	input wire logic sys_clk,
	input wire logic rst,
	input apb_req_t req,
	output apb_rsp_t rsp,
	input wire logic rx_valid,
	input fifo_status_t fifo,
	input spi_word_t rd_word,
	output logic pop,
	input wire logic miso_ready,
	input wire logic busy,
	output logic miso_start,
	output spi_word_t tx_word
);

	reg_addr_t addr;
	logic access;
	logic mapped;
	logic tx_pending;
	logic overflow;
	status_reg_t status;
	spi_word_t rdata;

	// access phase, pready is always high so one cycle only
	assign access = req.psel & req.penable;
	assign addr = reg_addr_t'(req.paddr);

	assign status.rx_count = fifo.count;
	assign status.rx_empty = fifo.empty;
	assign status.tx_pending = tx_pending;
	assign status.overflow = overflow;
	assign status.busy = busy;

	// address decode and read mux
	always_comb begin
		mapped = 1'b1;
		rdata = '0;
		case (addr)
			addr_status: rdata = status;
			addr_rxdata: rdata = rd_word;
			addr_txdata: rdata = tx_word;
			default: mapped = 1'b0;
		endcase
	end

	assign rsp.prdata = rdata;
	assign rsp.pready = 1'b1;
	assign rsp.pslverr = access & ~mapped;

	// head word leaves the fifo at the end of the read
	assign pop = access && !req.pwrite && addr == addr_rxdata;

	// hand off whenever the driver is waiting and a word is staged
	assign miso_start = miso_ready & tx_pending;

	// tx word, payload only
	always_ff @(posedge sys_clk) begin
		if (access && req.pwrite && addr == addr_txdata) begin
			tx_word <= req.pwdata;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (rst) begin
			tx_pending <= 1'b0;
			overflow <= 1'b0;
		end else begin
			// new write beats a hand-off in the same cycle
			if (access && req.pwrite && addr == addr_txdata) begin
				tx_pending <= 1'b1;
			end else if (miso_start) begin
				tx_pending <= 1'b0;
			end
			// word lost to a full fifo, set has priority over clear
			if (rx_valid && fifo.full) begin
				overflow <= 1'b1;
			end else if (access && req.pwrite && addr == addr_status && req.pwdata[0]) begin
				overflow <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

/* spi_rx_fifo.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// receive fifo
// circular buffer of spi words with
// count, empty and full status
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module spi_rx_fifo import spi_slave_pkg::*; #(
	parameter int fifo_depth = 8
) (
	input wire logic sys_clk,
	input wire logic rst,
	input wire logic push,
	input spi_word_t wr_word,
	input wire logic pop,
	output spi_word_t rd_word,
	output fifo_status_t status
);

	localparam int PTR_W = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;

	spi_word_t mem [fifo_depth];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	fifo_cnt_t cnt;
	logic do_push;
	logic do_pop;

	// wrap at depth, which need not be a power of two
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(fifo_depth - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign status.count = cnt;
	assign status.empty = (cnt == '0);
	assign status.full = (cnt == fifo_cnt_t'(fifo_depth));

	// full push dropped, empty pop ignored
	assign do_push = push && !status.full;
	assign do_pop = pop && !status.empty;

	// head word, zero when nothing stored
	assign rd_word = status.empty ? '0 : mem[rd_ptr];

	always_ff @(posedge sys_clk) begin
		if (do_push) begin
			mem[wr_ptr] <= wr_word;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			cnt <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (do_pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			// simultaneous push and pop keeps the count
			if (do_push && !do_pop) begin
				cnt <= cnt + 1'b1;
			end else if (do_pop && !do_push) begin
				cnt <= cnt - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* spi_slave_driver.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// spi mode 0 slave driver
// transaction fsm with mosi sampling on
// sclk rise and miso shifting on fall
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module spi_slave_driver import spi_slave_pkg::*; #(
	parameter bit ss_active_low = 1'b1,
	parameter bit lsb_first = 1'b0
) (
	input wire logic sys_clk,
	input wire logic rst,
	input spi_sync_t sync,
	input wire logic miso_start,
	input spi_word_t tx_word,
	output logic miso_ready,
	output logic rx_valid,
	output spi_word_t rx_word,
	output logic busy,
	output logic miso
);

	drv_state_t state;
	spi_word_t rx_sr;
	spi_word_t tx_sr;
	bit_cnt_t rx_cnt;
	bit_cnt_t tx_cnt;
	logic ss_act;
	logic rx_armed;
	logic tx_armed;

	// ss polarity folded here, rest of the logic sees active high
	assign ss_act = ss_active_low ? ~sync.ss : sync.ss;
	assign busy = ss_act;

	// sample window covers the gap before the first rise too
	assign rx_armed = ss_act && (state == st_miso_ready || state == st_comm_start ||
		state == st_wait_mosi);
	assign tx_armed = ss_act && (state == st_wait_mosi || state == st_wait_miso);

	// rx_sr stays put until the next rise, well after rx_valid
	assign rx_word = rx_sr;
	assign miso = lsb_first ? tx_sr[0] : tx_sr[WORD_BITS-1];

	// mosi shift register, payload only
	always_ff @(posedge sys_clk) begin
		if (rx_armed && sync.sclk_rise) begin
			if (lsb_first) begin
				rx_sr <= {sync.mosi, rx_sr[WORD_BITS-1:1]};
			end else begin
				rx_sr <= {rx_sr[WORD_BITS-2:0], sync.mosi};
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (rst) begin
			state <= st_reset;
			miso_ready <= 1'b0;
			rx_valid <= 1'b0;
			rx_cnt <= '0;
			tx_cnt <= '0;
			tx_sr <= '0;
		end else begin
			rx_valid <= 1'b0;
			if (rx_armed && sync.sclk_rise) begin
				rx_cnt <= rx_cnt + 1'b1;
			end
			// zeros shift in behind, so an unloaded word sends zeros
			if (tx_armed && sync.sclk_fall) begin
				tx_cnt <= tx_cnt + 1'b1;
				if (lsb_first) begin
					tx_sr <= {1'b0, tx_sr[WORD_BITS-1:1]};
				end else begin
					tx_sr <= {tx_sr[WORD_BITS-2:0], 1'b0};
				end
			end
			unique case (state)
				st_reset: begin
					miso_ready <= 1'b0;
					rx_cnt <= '0;
					tx_cnt <= '0;
					tx_sr <= '0;
					state <= st_idle;
				end
				// wait for select
				st_idle: begin
					if (ss_act) begin
						miso_ready <= 1'b1;
						state <= st_miso_ready;
					end
				end
				st_miso_ready: begin
					if (!ss_act) begin
						miso_ready <= 1'b0;
						state <= st_reset;
					end else if (sync.sclk_rise) begin
						// first bit already sampled, too late to load
						miso_ready <= 1'b0;
						state <= st_wait_mosi;
					end else if (miso_start) begin
						miso_ready <= 1'b0;
						tx_sr <= tx_word;
						state <= st_comm_start;
					end
				end
				// word loaded, first bit now on miso
				st_comm_start: begin
					state <= ss_act ? st_wait_mosi : st_reset;
				end
				st_wait_mosi: begin
					if (!ss_act) begin
						state <= st_reset;
					end else if (rx_cnt == bit_cnt_t'(WORD_BITS)) begin
						rx_valid <= 1'b1;
						state <= st_wait_miso;
					end
				end
				// last fall ends the word
				st_wait_miso: begin
					if (!ss_act) begin
						state <= st_reset;
					end else if (tx_cnt == bit_cnt_t'(WORD_BITS) && !sync.sclk) begin
						rx_cnt <= '0;
						tx_cnt <= '0;
						miso_ready <= 1'b1;
						state <= st_miso_ready;
					end
				end
				default: begin
					miso_ready <= 1'b0;
					state <= st_reset;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* spi_line_sync.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// spi pin synchronizer
// brings ss, sclk, mosi into sys_clk
// and forms sclk rise and fall pulses
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module spi_line_sync import spi_slave_pkg::*; (
	input wire logic sys_clk,
	input wire logic rst,
	input spi_pins_t pins,
	output spi_sync_t sync
);

	// two stages for ss and mosi
	logic [1:0] ss_q;
	logic [1:0] mosi_q;
	// sclk gets a third stage for edge detect
	logic [2:0] sclk_q;

	always_ff @(posedge sys_clk) begin
		ss_q <= {ss_q[0], pins.ss};
		mosi_q <= {mosi_q[0], pins.mosi};
	end

	// history held low in reset, no false edge afterwards
	always_ff @(posedge sys_clk) begin
		if (rst) begin
			sclk_q <= '0;
		end else begin
			sclk_q <= {sclk_q[1:0], pins.sclk};
		end
	end

	assign sync.ss = ss_q[1];
	assign sync.mosi = mosi_q[1];
	assign sync.sclk = sclk_q[1];
	// one cycle pulses, compare stage 2 against stage 3
	assign sync.sclk_rise = sclk_q[1] & ~sclk_q[2];
	assign sync.sclk_fall = ~sclk_q[1] & sclk_q[2];

endmodule

`default_nettype wire

/* spi_slave_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// spi slave shared definitions
// word, pin, apb and status types plus
// the driver states and register map
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package spi_slave_pkg;

	// data word width, fixed
	localparam int WORD_BITS = 8;
	// bit counter must hold WORD_BITS itself
	localparam int BIT_CNT_W = $clog2(WORD_BITS + 1);

	typedef logic [WORD_BITS-1:0] spi_word_t;
	typedef logic [BIT_CNT_W-1:0] bit_cnt_t;
	// fifo occupancy, wide enough for depths up to 15
	typedef logic [3:0] fifo_cnt_t;

	// raw pins from the master
	typedef struct packed {
		logic ss;
		logic sclk;
		logic mosi;
	} spi_pins_t;

	// pins after the synchronizer, with sclk edge pulses
	typedef struct packed {
		logic ss;
		logic sclk;
		logic mosi;
		logic sclk_rise;
		logic sclk_fall;
	} spi_sync_t;

	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		logic [3:0] paddr;
		spi_word_t pwdata;
	} apb_req_t;

	typedef struct packed {
		spi_word_t prdata;
		logic pready;
		logic pslverr;
	} apb_rsp_t;

	typedef struct packed {
		fifo_cnt_t count;
		logic empty;
		logic full;
	} fifo_status_t;

	// STATUS register layout, busy in bit 0
	typedef struct packed {
		fifo_cnt_t rx_count;
		logic rx_empty;
		logic tx_pending;
		logic overflow;
		logic busy;
	} status_reg_t;

	typedef enum logic [2:0] {
		st_reset,
		st_idle,
		st_miso_ready,
		st_comm_start,
		st_wait_mosi,
		st_wait_miso
	} drv_state_t;

	// apb register map
	typedef enum logic [3:0] {
		addr_status = 4'h0,
		addr_rxdata = 4'h4,
		addr_txdata = 4'h8
	} reg_addr_t;

endpackage

`default_nettype wire
